// File: design/soc_cfg_pkg.sv
package soc_cfg_pkg;

    // Bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // Each RAM holds 1024 words
    localparam int RAM_DEPTH       = 1024;
    localparam int WORD_ADDR_WIDTH = $clog2(RAM_DEPTH);
    localparam int RAM_BYTES       = RAM_DEPTH * STRB_WIDTH;

    // Memory map in 64 KB regions
    localparam int REGION_LSB  = 16;
    localparam int REGION_IRAM = 0;
    localparam int REGION_DRAM = 1;

    localparam int NUM_MASTERS = 2;

    typedef logic [ADDR_WIDTH-1:0]      addr_t;
    typedef logic [DATA_WIDTH-1:0]      data_t;
    typedef logic [STRB_WIDTH-1:0]      strb_t;
    typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;

endpackage

// File: design/bus_pkg.sv
package bus_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    // Same codes as AXI OKAY and DECERR
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11
    } bus_resp_e;

    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_BUSY = 1'b1
    } arb_state_e;

endpackage

// File: design/master_port_decode.sv
`timescale 1ns/10ps

module master_port_decode (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  bus_pkg::bus_op_e        req_op_i,
    input  soc_cfg_pkg::addr_t      req_addr_i,
    input  soc_cfg_pkg::data_t      req_wdata_i,
    input  soc_cfg_pkg::strb_t      req_strb_i,
    output logic                    resp_valid_o,
    input  logic                    resp_ready_i,
    output soc_cfg_pkg::data_t      resp_rdata_o,
    output bus_pkg::bus_resp_e      resp_resp_o,
    output logic                    iram_valid_o,
    output logic                    dram_valid_o,
    output bus_pkg::bus_op_e        slv_op_o,
    output soc_cfg_pkg::word_addr_t slv_word_addr_o,
    output soc_cfg_pkg::data_t      slv_wdata_o,
    output soc_cfg_pkg::strb_t      slv_strb_o,
    input  logic                    iram_ready_i,
    input  logic                    dram_ready_i,
    input  logic                    iram_resp_valid_i,
    input  logic                    dram_resp_valid_i,
    input  soc_cfg_pkg::data_t      iram_rdata_i,
    input  soc_cfg_pkg::data_t      dram_rdata_i,
    input  bus_pkg::bus_resp_e      iram_resp_i,
    input  bus_pkg::bus_resp_e      dram_resp_i,
    output logic                    slv_resp_ready_o
);

    logic [soc_cfg_pkg::ADDR_WIDTH-soc_cfg_pkg::REGION_LSB-1:0] region;
    logic [soc_cfg_pkg::REGION_LSB-1:0] offset;
    logic in_range;
    logic sel_iram;
    logic sel_dram;
    logic pend_iram_q;
    logic pend_dram_q;
    logic pend_err_q;
    logic busy;

    assign region   = req_addr_i[soc_cfg_pkg::ADDR_WIDTH-1:soc_cfg_pkg::REGION_LSB];
    assign offset   = req_addr_i[soc_cfg_pkg::REGION_LSB-1:0];
    assign in_range = offset < soc_cfg_pkg::RAM_BYTES;
    assign sel_iram = in_range && (region == soc_cfg_pkg::REGION_IRAM);
    assign sel_dram = in_range && (region == soc_cfg_pkg::REGION_DRAM);
    assign busy     = pend_iram_q || pend_dram_q || pend_err_q;

    // One request outstanding per master
    assign iram_valid_o = req_valid_i && sel_iram && !busy;
    assign dram_valid_o = req_valid_i && sel_dram && !busy;
    assign req_ready_o  = !busy && (sel_iram ? iram_ready_i :
                                    sel_dram ? dram_ready_i : 1'b1);

    assign slv_op_o        = req_op_i;
    assign slv_word_addr_o = offset[$clog2(soc_cfg_pkg::STRB_WIDTH) +: soc_cfg_pkg::WORD_ADDR_WIDTH];
    assign slv_wdata_o     = req_wdata_i;
    assign slv_strb_o      = req_strb_i;
    assign slv_resp_ready_o = resp_ready_i;

    // Response from whichever slave owns the request
    always_comb begin
        resp_valid_o = pend_err_q;
        resp_rdata_o = '0;
        resp_resp_o  = bus_pkg::RESP_DECERR;
        if (pend_iram_q) begin
            resp_valid_o = iram_resp_valid_i;
            resp_rdata_o = iram_rdata_i;
            resp_resp_o  = iram_resp_i;
        end else if (pend_dram_q) begin
            resp_valid_o = dram_resp_valid_i;
            resp_rdata_o = dram_rdata_i;
            resp_resp_o  = dram_resp_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pend_iram_q <= 1'b0;
            pend_dram_q <= 1'b0;
            pend_err_q  <= 1'b0;
        end else if (resp_valid_o && resp_ready_i) begin
            pend_iram_q <= 1'b0;
            pend_dram_q <= 1'b0;
            pend_err_q  <= 1'b0;
        end else if (req_valid_i && req_ready_o) begin
            pend_iram_q <= sel_iram;
            pend_dram_q <= sel_dram;
            pend_err_q  <= !sel_iram && !sel_dram;
        end
    end

endmodule

// File: design/slave_arbiter.sv
`timescale 1ns/10ps

module slave_arbiter (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    m0_valid_i,
    input  logic                    m1_valid_i,
    input  bus_pkg::bus_op_e        m0_op_i,
    input  bus_pkg::bus_op_e        m1_op_i,
    input  soc_cfg_pkg::word_addr_t m0_word_addr_i,
    input  soc_cfg_pkg::word_addr_t m1_word_addr_i,
    input  soc_cfg_pkg::data_t      m0_wdata_i,
    input  soc_cfg_pkg::data_t      m1_wdata_i,
    input  soc_cfg_pkg::strb_t      m0_strb_i,
    input  soc_cfg_pkg::strb_t      m1_strb_i,
    input  logic                    m0_resp_ready_i,
    input  logic                    m1_resp_ready_i,
    output logic                    m0_ready_o,
    output logic                    m1_ready_o,
    output logic                    m0_resp_valid_o,
    output logic                    m1_resp_valid_o,
    output logic                    ram_valid_o,
    input  logic                    ram_ready_i,
    output bus_pkg::bus_op_e        ram_op_o,
    output soc_cfg_pkg::word_addr_t ram_word_addr_o,
    output soc_cfg_pkg::data_t      ram_wdata_o,
    output soc_cfg_pkg::strb_t      ram_strb_o,
    input  logic                    ram_resp_valid_i,
    output logic                    ram_resp_ready_o
);

    bus_pkg::arb_state_e state_q;
    // Last granted master, also the owner while busy
    logic [$clog2(soc_cfg_pkg::NUM_MASTERS)-1:0] grant_q;
    logic idle;
    logic pick_m0;
    logic pick_m1;

    assign idle = (state_q == bus_pkg::ARB_IDLE);

    // Round robin, the master not granted last wins a tie
    assign pick_m0 = m0_valid_i && !(m1_valid_i && grant_q == 1'b0);
    assign pick_m1 = m1_valid_i && !(m0_valid_i && grant_q == 1'b1);

    assign m0_ready_o = idle && ram_ready_i && !pick_m1;
    assign m1_ready_o = idle && ram_ready_i && !pick_m0;

    assign ram_valid_o     = idle && (m0_valid_i || m1_valid_i);
    assign ram_op_o        = pick_m1 ? m1_op_i        : m0_op_i;
    assign ram_word_addr_o = pick_m1 ? m1_word_addr_i : m0_word_addr_i;
    assign ram_wdata_o     = pick_m1 ? m1_wdata_i     : m0_wdata_i;
    assign ram_strb_o      = pick_m1 ? m1_strb_i      : m0_strb_i;

    // Response goes only to the owner
    assign m0_resp_valid_o  = ram_resp_valid_i && !idle && (grant_q == 1'b0);
    assign m1_resp_valid_o  = ram_resp_valid_i && !idle && (grant_q == 1'b1);
    assign ram_resp_ready_o = !idle && (grant_q == 1'b1 ? m1_resp_ready_i : m0_resp_ready_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= bus_pkg::ARB_IDLE;
            grant_q <= 1'b1;
        end else begin
            case (state_q)
                bus_pkg::ARB_IDLE: begin
                    if (ram_valid_o && ram_ready_i) begin
                        state_q <= bus_pkg::ARB_BUSY;
                        grant_q <= pick_m1;
                    end
                end
                bus_pkg::ARB_BUSY: begin
                    if (ram_resp_valid_i && ram_resp_ready_o) begin
                        state_q <= bus_pkg::ARB_IDLE;
                    end
                end
                default: state_q <= bus_pkg::ARB_IDLE;
            endcase
        end
    end

endmodule

// File: design/sram_slave.sv
`timescale 1ns/10ps

module sram_slave (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  bus_pkg::bus_op_e        req_op_i,
    input  soc_cfg_pkg::word_addr_t req_word_addr_i,
    input  soc_cfg_pkg::data_t      req_wdata_i,
    input  soc_cfg_pkg::strb_t      req_strb_i,
    output logic                    resp_valid_o,
    input  logic                    resp_ready_i,
    output soc_cfg_pkg::data_t      resp_rdata_o,
    output bus_pkg::bus_resp_e      resp_resp_o
);

    soc_cfg_pkg::data_t mem [soc_cfg_pkg::RAM_DEPTH];
    soc_cfg_pkg::data_t rdata_q;
    logic               resp_valid_q;
    logic               accept;

    // New request only once the response register is free
    assign req_ready_o = !resp_valid_q;
    assign accept      = req_valid_i && req_ready_o;

    assign resp_valid_o = resp_valid_q;
    assign resp_rdata_o = rdata_q;
    // Every RAM access succeeds
    assign resp_resp_o  = bus_pkg::RESP_OKAY;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            resp_valid_q <= 1'b0;
        end else if (accept) begin
            resp_valid_q <= 1'b1;
        end else if (resp_ready_i) begin
            resp_valid_q <= 1'b0;
        end
    end

    // Byte lane writes
    always_ff @(posedge clk_i) begin
        if (accept && req_op_i == bus_pkg::OP_WRITE) begin
            for (int b = 0; b < soc_cfg_pkg::STRB_WIDTH; b++) begin
                if (req_strb_i[b]) begin
                    mem[req_word_addr_i][8*b +: 8] <= req_wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Read data captured at acceptance, zero for writes
    always_ff @(posedge clk_i) begin
        if (accept) begin
            if (req_op_i == bus_pkg::OP_READ) begin
                rdata_q <= mem[req_word_addr_i];
            end else begin
                rdata_q <= '0;
            end
        end
    end

endmodule

// File: design/soc_mem_top.sv
`timescale 1ns/10ps

module soc_mem_top (
    input  logic                clk_i,
    input  logic                rst_i,
    // Instruction side master
    input  logic                req_valid_m0_i,
    output logic                req_ready_m0_o,
    input  bus_pkg::bus_op_e    req_op_m0_i,
    input  soc_cfg_pkg::addr_t  req_addr_m0_i,
    input  soc_cfg_pkg::data_t  req_wdata_m0_i,
    input  soc_cfg_pkg::strb_t  req_strb_m0_i,
    output logic                resp_valid_m0_o,
    input  logic                resp_ready_m0_i,
    output soc_cfg_pkg::data_t  resp_rdata_m0_o,
    output bus_pkg::bus_resp_e  resp_resp_m0_o,
    // Data side master
    input  logic                req_valid_m1_i,
    output logic                req_ready_m1_o,
    input  bus_pkg::bus_op_e    req_op_m1_i,
    input  soc_cfg_pkg::addr_t  req_addr_m1_i,
    input  soc_cfg_pkg::data_t  req_wdata_m1_i,
    input  soc_cfg_pkg::strb_t  req_strb_m1_i,
    output logic                resp_valid_m1_o,
    input  logic                resp_ready_m1_i,
    output soc_cfg_pkg::data_t  resp_rdata_m1_o,
    output bus_pkg::bus_resp_e  resp_resp_m1_o
);

    // Decoder side
    logic                    d0_iram_valid, d0_dram_valid, d0_resp_ready;
    logic                    d1_iram_valid, d1_dram_valid, d1_resp_ready;
    bus_pkg::bus_op_e        d0_op, d1_op;
    soc_cfg_pkg::word_addr_t d0_word_addr, d1_word_addr;
    soc_cfg_pkg::data_t      d0_wdata, d1_wdata;
    soc_cfg_pkg::strb_t      d0_strb, d1_strb;

    // Arbiter to master
    logic iram_m0_ready, iram_m1_ready, iram_m0_resp_valid, iram_m1_resp_valid;
    logic dram_m0_ready, dram_m1_ready, dram_m0_resp_valid, dram_m1_resp_valid;

    // Arbiter to RAM
    logic                    iram_req_valid, iram_req_ready, iram_resp_valid, iram_resp_ready;
    logic                    dram_req_valid, dram_req_ready, dram_resp_valid, dram_resp_ready;
    bus_pkg::bus_op_e        iram_op, dram_op;
    soc_cfg_pkg::word_addr_t iram_word_addr, dram_word_addr;
    soc_cfg_pkg::data_t      iram_wdata, dram_wdata;
    soc_cfg_pkg::strb_t      iram_strb, dram_strb;
    soc_cfg_pkg::data_t      iram_rdata, dram_rdata;
    bus_pkg::bus_resp_e      iram_resp, dram_resp;

    master_port_decode u_dec_m0 (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .req_valid_i       (req_valid_m0_i),
        .req_ready_o       (req_ready_m0_o),
        .req_op_i          (req_op_m0_i),
        .req_addr_i        (req_addr_m0_i),
        .req_wdata_i       (req_wdata_m0_i),
        .req_strb_i        (req_strb_m0_i),
        .resp_valid_o      (resp_valid_m0_o),
        .resp_ready_i      (resp_ready_m0_i),
        .resp_rdata_o      (resp_rdata_m0_o),
        .resp_resp_o       (resp_resp_m0_o),
        .iram_valid_o      (d0_iram_valid),
        .dram_valid_o      (d0_dram_valid),
        .slv_op_o          (d0_op),
        .slv_word_addr_o   (d0_word_addr),
        .slv_wdata_o       (d0_wdata),
        .slv_strb_o        (d0_strb),
        .iram_ready_i      (iram_m0_ready),
        .dram_ready_i      (dram_m0_ready),
        .iram_resp_valid_i (iram_m0_resp_valid),
        .dram_resp_valid_i (dram_m0_resp_valid),
        .iram_rdata_i      (iram_rdata),
        .dram_rdata_i      (dram_rdata),
        .iram_resp_i       (iram_resp),
        .dram_resp_i       (dram_resp),
        .slv_resp_ready_o  (d0_resp_ready)
    );

    master_port_decode u_dec_m1 (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .req_valid_i       (req_valid_m1_i),
        .req_ready_o       (req_ready_m1_o),
        .req_op_i          (req_op_m1_i),
        .req_addr_i        (req_addr_m1_i),
        .req_wdata_i       (req_wdata_m1_i),
        .req_strb_i        (req_strb_m1_i),
        .resp_valid_o      (resp_valid_m1_o),
        .resp_ready_i      (resp_ready_m1_i),
        .resp_rdata_o      (resp_rdata_m1_o),
        .resp_resp_o       (resp_resp_m1_o),
        .iram_valid_o      (d1_iram_valid),
        .dram_valid_o      (d1_dram_valid),
        .slv_op_o          (d1_op),
        .slv_word_addr_o   (d1_word_addr),
        .slv_wdata_o       (d1_wdata),
        .slv_strb_o        (d1_strb),
        .iram_ready_i      (iram_m1_ready),
        .dram_ready_i      (dram_m1_ready),
        .iram_resp_valid_i (iram_m1_resp_valid),
        .dram_resp_valid_i (dram_m1_resp_valid),
        .iram_rdata_i      (iram_rdata),
        .dram_rdata_i      (dram_rdata),
        .iram_resp_i       (iram_resp),
        .dram_resp_i       (dram_resp),
        .slv_resp_ready_o  (d1_resp_ready)
    );

    slave_arbiter u_arb_iram (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .m0_valid_i       (d0_iram_valid),
        .m1_valid_i       (d1_iram_valid),
        .m0_op_i          (d0_op),
        .m1_op_i          (d1_op),
        .m0_word_addr_i   (d0_word_addr),
        .m1_word_addr_i   (d1_word_addr),
        .m0_wdata_i       (d0_wdata),
        .m1_wdata_i       (d1_wdata),
        .m0_strb_i        (d0_strb),
        .m1_strb_i        (d1_strb),
        .m0_resp_ready_i  (d0_resp_ready),
        .m1_resp_ready_i  (d1_resp_ready),
        .m0_ready_o       (iram_m0_ready),
        .m1_ready_o       (iram_m1_ready),
        .m0_resp_valid_o  (iram_m0_resp_valid),
        .m1_resp_valid_o  (iram_m1_resp_valid),
        .ram_valid_o      (iram_req_valid),
        .ram_ready_i      (iram_req_ready),
        .ram_op_o         (iram_op),
        .ram_word_addr_o  (iram_word_addr),
        .ram_wdata_o      (iram_wdata),
        .ram_strb_o       (iram_strb),
        .ram_resp_valid_i (iram_resp_valid),
        .ram_resp_ready_o (iram_resp_ready)
    );

    slave_arbiter u_arb_dram (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .m0_valid_i       (d0_dram_valid),
        .m1_valid_i       (d1_dram_valid),
        .m0_op_i          (d0_op),
        .m1_op_i          (d1_op),
        .m0_word_addr_i   (d0_word_addr),
        .m1_word_addr_i   (d1_word_addr),
        .m0_wdata_i       (d0_wdata),
        .m1_wdata_i       (d1_wdata),
        .m0_strb_i        (d0_strb),
        .m1_strb_i        (d1_strb),
        .m0_resp_ready_i  (d0_resp_ready),
        .m1_resp_ready_i  (d1_resp_ready),
        .m0_ready_o       (dram_m0_ready),
        .m1_ready_o       (dram_m1_ready),
        .m0_resp_valid_o  (dram_m0_resp_valid),
        .m1_resp_valid_o  (dram_m1_resp_valid),
        .ram_valid_o      (dram_req_valid),
        .ram_ready_i      (dram_req_ready),
        .ram_op_o         (dram_op),
        .ram_word_addr_o  (dram_word_addr),
        .ram_wdata_o      (dram_wdata),
        .ram_strb_o       (dram_strb),
        .ram_resp_valid_i (dram_resp_valid),
        .ram_resp_ready_o (dram_resp_ready)
    );

    sram_slave u_iram (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .req_valid_i     (iram_req_valid),
        .req_ready_o     (iram_req_ready),
        .req_op_i        (iram_op),
        .req_word_addr_i (iram_word_addr),
        .req_wdata_i     (iram_wdata),
        .req_strb_i      (iram_strb),
        .resp_valid_o    (iram_resp_valid),
        .resp_ready_i    (iram_resp_ready),
        .resp_rdata_o    (iram_rdata),
        .resp_resp_o     (iram_resp)
    );

    sram_slave u_dram (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .req_valid_i     (dram_req_valid),
        .req_ready_o     (dram_req_ready),
        .req_op_i        (dram_op),
        .req_word_addr_i (dram_word_addr),
        .req_wdata_i     (dram_wdata),
        .req_strb_i      (dram_strb),
        .resp_valid_o    (dram_resp_valid),
        .resp_ready_i    (dram_resp_ready),
        .resp_rdata_o    (dram_rdata),
        .resp_resp_o     (dram_resp)
    );

endmodule

// File: verif/tb_soc_mem_tasks.svh
// Reference model, one word array per RAM
soc_cfg_pkg::data_t model_mem [2][soc_cfg_pkg::RAM_DEPTH];
// Master that owned each RAM last, for round robin
int last_grant [2];
int last_resp_cycle [2];

function automatic soc_cfg_pkg::data_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic soc_cfg_pkg::addr_t make_addr(int region, int word);
    return (soc_cfg_pkg::addr_t'(region) << soc_cfg_pkg::REGION_LSB) |
           (soc_cfg_pkg::addr_t'(word) << 2);
endfunction

// Per master view of the DUT outputs
function automatic logic ready_of(int m);
    return (m == 0) ? req_ready_m0 : req_ready_m1;
endfunction

function automatic logic valid_of(int m);
    return (m == 0) ? resp_valid_m0 : resp_valid_m1;
endfunction

function automatic soc_cfg_pkg::data_t rdata_of(int m);
    return (m == 0) ? resp_rdata_m0 : resp_rdata_m1;
endfunction

function automatic bus_pkg::bus_resp_e resp_of(int m);
    return (m == 0) ? resp_resp_m0 : resp_resp_m1;
endfunction

task automatic fail_run();
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
endtask

task automatic expect_true(logic cond, string what);
    if (cond !== 1'b1) begin
        $display("Failure at time %0t: %s", $time, what);
        fail_run();
    end
endtask

task automatic check_data(string name, soc_cfg_pkg::data_t got, soc_cfg_pkg::data_t exp);
    if (got !== exp) begin
        $display("Error: time %0t, %s = %h, expected %h", $time, name, got, exp);
        fail_run();
    end
endtask

task automatic check_resp(string name, bus_pkg::bus_resp_e got, bus_pkg::bus_resp_e exp);
    if (got !== exp) begin
        $display("Error: time %0t, %s = %s (%b), expected %s", $time, name,
                 got.name(), got, exp.name());
        fail_run();
    end
endtask

task automatic issue_req(int m, bus_pkg::bus_op_e op, soc_cfg_pkg::addr_t addr,
                         soc_cfg_pkg::data_t wdata, soc_cfg_pkg::strb_t strb,
                         output int acc_cycle);
    @(posedge clk);
    req_valid[m] <= 1'b1;
    req_op[m]    <= op;
    req_addr[m]  <= addr;
    req_wdata[m] <= wdata;
    req_strb[m]  <= strb;
    @(negedge clk);
    while (!ready_of(m)) begin
        @(negedge clk);
    end
    acc_cycle = cycle_cnt;
    // Transfer happens on this edge
    @(posedge clk);
    req_valid[m] <= 1'b0;
endtask

task automatic access(int m, bus_pkg::bus_op_e op, soc_cfg_pkg::addr_t addr,
                      soc_cfg_pkg::data_t wdata, soc_cfg_pkg::strb_t strb,
                      output soc_cfg_pkg::data_t rdata, output bus_pkg::bus_resp_e resp);
    int acc_cycle;
    issue_req(m, op, addr, wdata, strb, acc_cycle);
    @(negedge clk);
    while (!valid_of(m)) begin
        @(negedge clk);
    end
    expect_true(cycle_cnt == acc_cycle + 1, "response did not follow acceptance by one cycle");
    rdata = rdata_of(m);
    resp  = resp_of(m);
    last_resp_cycle[m] = cycle_cnt;
    @(posedge clk);
endtask

task automatic write_word(int m, int r, int word, soc_cfg_pkg::data_t data,
                          soc_cfg_pkg::strb_t strb);
    soc_cfg_pkg::data_t rdata;
    bus_pkg::bus_resp_e resp;
    access(m, bus_pkg::OP_WRITE, make_addr(r, word), data, strb, rdata, resp);
    check_resp($sformatf("resp_resp_m%0d", m), resp, bus_pkg::RESP_OKAY);
    check_data($sformatf("resp_rdata_m%0d", m), rdata, '0);
    for (int b = 0; b < soc_cfg_pkg::STRB_WIDTH; b++) begin
        if (strb[b]) begin
            model_mem[r][word][8*b +: 8] = data[8*b +: 8];
        end
    end
    last_grant[r] = m;
endtask

task automatic read_check(int m, int r, int word);
    soc_cfg_pkg::data_t rdata;
    bus_pkg::bus_resp_e resp;
    access(m, bus_pkg::OP_READ, make_addr(r, word), '0, '0, rdata, resp);
    check_resp($sformatf("resp_resp_m%0d", m), resp, bus_pkg::RESP_OKAY);
    check_data($sformatf("resp_rdata_m%0d", m), rdata, model_mem[r][word]);
    last_grant[r] = m;
endtask

task automatic decerr_check(int m, soc_cfg_pkg::addr_t addr, bus_pkg::bus_op_e op,
                            soc_cfg_pkg::data_t wdata);
    soc_cfg_pkg::data_t rdata;
    bus_pkg::bus_resp_e resp;
    access(m, op, addr, wdata, '1, rdata, resp);
    check_resp($sformatf("resp_resp_m%0d", m), resp, bus_pkg::RESP_DECERR);
    check_data($sformatf("resp_rdata_m%0d", m), rdata, '0);
endtask

// File: verif/tb_soc_mem.sv
`timescale 1ns/10ps

module tb_soc_mem;

    localparam int WORDS_PER_TEST = 64;
    // About twice the run length at three cycles per access
    localparam int TIMEOUT_CYCLES = 4000;

    logic                      clk;
    logic                      rst;
    logic                      req_valid [2];
    bus_pkg::bus_op_e          req_op [2];
    soc_cfg_pkg::addr_t        req_addr [2];
    soc_cfg_pkg::data_t        req_wdata [2];
    soc_cfg_pkg::strb_t        req_strb [2];
    logic                      resp_ready [2];
    logic                      req_ready_m0, req_ready_m1;
    logic                      resp_valid_m0, resp_valid_m1;
    soc_cfg_pkg::data_t        resp_rdata_m0, resp_rdata_m1;
    bus_pkg::bus_resp_e        resp_resp_m0, resp_resp_m1;
    logic [31:0]               lcg_state;
    int                        cycle_cnt = 0;

    soc_mem_top soc_mem_top_inst (
        .clk_i           (clk),
        .rst_i           (rst),
        .req_valid_m0_i  (req_valid[0]),
        .req_ready_m0_o  (req_ready_m0),
        .req_op_m0_i     (req_op[0]),
        .req_addr_m0_i   (req_addr[0]),
        .req_wdata_m0_i  (req_wdata[0]),
        .req_strb_m0_i   (req_strb[0]),
        .resp_valid_m0_o (resp_valid_m0),
        .resp_ready_m0_i (resp_ready[0]),
        .resp_rdata_m0_o (resp_rdata_m0),
        .resp_resp_m0_o  (resp_resp_m0),
        .req_valid_m1_i  (req_valid[1]),
        .req_ready_m1_o  (req_ready_m1),
        .req_op_m1_i     (req_op[1]),
        .req_addr_m1_i   (req_addr[1]),
        .req_wdata_m1_i  (req_wdata[1]),
        .req_strb_m1_i   (req_strb[1]),
        .resp_valid_m1_o (resp_valid_m1),
        .resp_ready_m1_i (resp_ready[1]),
        .resp_rdata_m1_o (resp_rdata_m1),
        .resp_resp_m1_o  (resp_resp_m1)
    );

    `include "tb_soc_mem_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        fail_run();
    end

    task automatic apply_reset();
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // Arbiters restart as if master 1 went last
        last_grant[0] = 1;
        last_grant[1] = 1;
        @(negedge clk);
        expect_true(req_ready_m0 && req_ready_m1, "req_ready not high after reset");
        expect_true(!resp_valid_m0 && !resp_valid_m1, "resp_valid not low after reset");
    endtask

    task automatic full_word_rw();
        for (int m = 0; m < 2; m++) begin
            for (int r = 0; r < 2; r++) begin
                for (int i = 0; i < WORDS_PER_TEST; i++) begin
                    write_word(m, r, m * WORDS_PER_TEST + i, next_rand(), '1);
                end
            end
        end
        // Each master reads what the other one wrote
        for (int m = 0; m < 2; m++) begin
            for (int r = 0; r < 2; r++) begin
                for (int i = 0; i < WORDS_PER_TEST; i++) begin
                    read_check(m, r, (1 - m) * WORDS_PER_TEST + i);
                end
            end
        end
    endtask

    task automatic partial_strobe_merge();
        for (int s = 1; s < 16; s++) begin
            write_word(s % 2, s / 8, 300 + s, next_rand(), '1);
            write_word(1 - s % 2, s / 8, 300 + s, next_rand(), soc_cfg_pkg::strb_t'(s));
            read_check(s % 2, s / 8, 300 + s);
        end
    endtask

    task automatic decode_error_accesses();
        decerr_check(0, make_addr(2, 16), bus_pkg::OP_WRITE, next_rand());
        decerr_check(1, make_addr(1, soc_cfg_pkg::RAM_DEPTH), bus_pkg::OP_WRITE, next_rand());
        decerr_check(1, make_addr(2, 16), bus_pkg::OP_READ, '0);
        // Words a wrong decode would alias onto
        read_check(0, 0, 16);
        read_check(0, 1, 16);
        read_check(1, 0, 0);
        read_check(1, 1, 0);
    endtask

    task automatic ram_isolation();
        soc_cfg_pkg::data_t d;
        d = next_rand();
        write_word(0, 0, 500, d, '1);
        write_word(1, 1, 500, ~d, '1);
        read_check(1, 0, 500);
        read_check(0, 1, 500);
    endtask

    task automatic contention_order();
        soc_cfg_pkg::data_t d0;
        soc_cfg_pkg::data_t d1;
        int winner;
        apply_reset();
        d0 = next_rand();
        d1 = next_rand();
        winner = (last_grant[0] == 0) ? 1 : 0;
        fork
            write_word(0, 0, 600, d0, '1);
            write_word(1, 0, 601, d1, '1);
        join
        expect_true(last_resp_cycle[winner] < last_resp_cycle[1 - winner],
                    "first contended pair served the wrong master first");
        // Lone master 0 access puts master 1 next in line
        read_check(0, 0, 600);
        winner = (last_grant[0] == 0) ? 1 : 0;
        fork
            read_check(0, 0, 601);
            read_check(1, 0, 600);
        join
        expect_true(last_resp_cycle[winner] < last_resp_cycle[1 - winner],
                    "second contended pair served the wrong master first");
    endtask

    task automatic backpressure_hold();
        soc_cfg_pkg::data_t held_data;
        bus_pkg::bus_resp_e held_resp;
        int acc_cycle;
        int hold_end;
        @(posedge clk);
        resp_ready[0] <= 1'b0;
        issue_req(0, bus_pkg::OP_READ, make_addr(0, 600), '0, '0, acc_cycle);
        @(negedge clk);
        expect_true(resp_valid_m0 && cycle_cnt == acc_cycle + 1,
                    "held response not valid one cycle after acceptance");
        held_data = resp_rdata_m0;
        held_resp = resp_resp_m0;
        check_data("resp_rdata_m0", held_data, model_mem[0][600]);
        check_resp("resp_resp_m0", held_resp, bus_pkg::RESP_OKAY);
        fork
            begin
                repeat (10) begin
                    @(negedge clk);
                    expect_true(resp_valid_m0, "resp_valid_m0 dropped under back-pressure");
                    check_data("resp_rdata_m0", resp_rdata_m0, held_data);
                    check_resp("resp_resp_m0", resp_resp_m0, held_resp);
                end
                hold_end = cycle_cnt;
            end
            read_check(1, 1, 40);
        join
        expect_true(last_resp_cycle[1] < hold_end,
                    "master 1 did not finish on the other RAM during back-pressure");
        @(posedge clk);
        resp_ready[0] <= 1'b1;
        @(posedge clk);
        read_check(0, 0, 600);
    endtask

    initial begin
        lcg_state = 32'h661a;
        rst = 1'b1;
        for (int m = 0; m < 2; m++) begin
            req_valid[m]  = 1'b0;
            req_op[m]     = bus_pkg::OP_READ;
            req_addr[m]   = '0;
            req_wdata[m]  = '0;
            req_strb[m]   = '0;
            resp_ready[m] = 1'b1;
        end
        apply_reset();
        full_word_rw();
        partial_strobe_merge();
        decode_error_accesses();
        ram_isolation();
        contention_order();
        backpressure_hold();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+verif
design/soc_cfg_pkg.sv
design/bus_pkg.sv
design/master_port_decode.sv
design/slave_arbiter.sv
design/sram_slave.sv
design/soc_mem_top.sv
verif/tb_soc_mem.sv

// File: Bender.yml
package:
  name: soc_mem

sources:
  - design/soc_cfg_pkg.sv
  - design/bus_pkg.sv
  - design/master_port_decode.sv
  - design/slave_arbiter.sv
  - design/sram_slave.sv
  - design/soc_mem_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_soc_mem.sv
